// ==== hw/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

    // operand and result width
    localparam int xlen = 32;

    // 32x32 product plus guard bits for the booth recoding
    localparam int pp_width = 68;

    // radix-4 groups over a 35-bit multiplier
    localparam int pp_count = 17;

    typedef logic [xlen-1:0] word_t;
    typedef logic [pp_width-1:0] pp_t;

    // low two bits of the RISC-V M-extension funct3
    typedef enum logic [1:0] {
        op_mul    = 2'b00,  // low word
        op_mulh   = 2'b01,  // high word, signed x signed
        op_mulhsu = 2'b10,  // high word, signed x unsigned
        op_mulhu  = 2'b11   // high word, unsigned x unsigned
    } mul_op_t;

    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_run  = 2'b01,
        st_done = 2'b10
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/csa_column.sv ====
`timescale 1ns/1ps
`default_nettype none

module csa_column (
    input  wire logic [16:0] bits,
    input  wire logic [13:0] cin,
    output logic [13:0]      cout_group,
    output logic             cout,
    output logic             sum
);

    // full adder, returns {carry, sum}
    function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
        fa = {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

    logic [13:0] c;      // carries into the next column
    logic [4:0]  s1;
    logic [3:0]  s2;
    logic [1:0]  s3;
    logic [1:0]  s4;
    logic        s5;

    // first level works on the column bits alone
    assign {c[0], s1[0]} = fa(bits[2],  bits[3],  bits[4]);
    assign {c[1], s1[1]} = fa(bits[5],  bits[6],  bits[7]);
    assign {c[2], s1[2]} = fa(bits[8],  bits[9],  bits[10]);
    assign {c[3], s1[3]} = fa(bits[11], bits[12], bits[13]);
    assign {c[4], s1[4]} = fa(bits[14], bits[15], bits[16]);

    // early carries from the lower column join here
    assign {c[5], s2[0]} = fa(s1[0],   s1[1],   s1[2]);
    assign {c[6], s2[1]} = fa(s1[3],   s1[4],   bits[0]);
    assign {c[7], s2[2]} = fa(bits[1], cin[0],  cin[1]);
    assign {c[8], s2[3]} = fa(cin[2],  cin[3],  cin[4]);

    assign {c[9],  s3[0]} = fa(s2[0], s2[1], s2[2]);
    assign {c[10], s3[1]} = fa(s2[3], cin[5], cin[6]);  // cin[8:7] wait a level

    assign {c[11], s4[0]} = fa(s3[0],  s3[1],  cin[7]);
    assign {c[12], s4[1]} = fa(cin[8], cin[9], cin[10]);

    assign {c[13], s5} = fa(s4[0], s4[1], cin[11]);

    // last cell, its carry leaves as cout
    assign {cout, sum} = fa(s5, cin[12], cin[13]);

    assign cout_group = c;

endmodule

`default_nettype wire

// ==== hw/booth_pp_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire logic             load,
    input  wire mul_pkg::word_t   op_a,
    input  wire mul_pkg::word_t   op_b,
    input  wire mul_pkg::mul_op_t op,
    output mul_pkg::mul_op_t      op_q,
    output mul_pkg::pp_t          pp [mul_pkg::pp_count]
);

    mul_pkg::word_t            a_q;
    mul_pkg::word_t            b_q;
    logic                      a_signed;
    logic                      b_signed;
    mul_pkg::pp_t              a_ext;   // multiplicand at full product width
    logic [mul_pkg::xlen+2:0]  b_ext;   // zero below bit 0, two extension bits on top

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q  <= '0;
            b_q  <= '0;
            op_q <= mul_pkg::op_mul;
        end else if (load) begin
            a_q  <= op_a;
            b_q  <= op_b;
            op_q <= op;
        end
    end

    // a is signed for mulh and mulhsu, b for mulh only
    assign a_signed = (op_q == mul_pkg::op_mulh) || (op_q == mul_pkg::op_mulhsu);
    assign b_signed = (op_q == mul_pkg::op_mulh);

    assign a_ext = {{(mul_pkg::pp_width - mul_pkg::xlen){a_signed & a_q[mul_pkg::xlen-1]}},
                    a_q};
    assign b_ext = {{2{b_signed & b_q[mul_pkg::xlen-1]}}, b_q, 1'b0};

    for (genvar i = 0; i < mul_pkg::pp_count; i++) begin : g_pp
        logic [2:0]   grp;   // overlapping triplet of the multiplier
        mul_pkg::pp_t mag;   // digit magnitude times multiplicand

        assign grp = b_ext[2*i+2:2*i];

        always_comb begin
            case (grp)
                3'b001, 3'b010, 3'b101, 3'b110: mag = a_ext;
                3'b011, 3'b100:                 mag = a_ext << 1;
                default:                        mag = '0;
            endcase
        end

        // top bit set means a negative digit
        assign pp[i] = (grp[2] ? (~mag + 1'b1) : mag) << (2 * i);
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(op_q));

endmodule

`default_nettype wire

// ==== hw/wallace_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module wallace_tree (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire mul_pkg::pp_t   pp [mul_pkg::pp_count],
    output mul_pkg::pp_t        sum_q,
    output mul_pkg::pp_t        carry_q
);

    // carries handed from one column to the next, the last cell's excluded
    localparam int carry_w = mul_pkg::pp_count - 3;

    logic [mul_pkg::pp_count-1:0] col_bits [mul_pkg::pp_width];
    logic [carry_w-1:0]           col_carry [mul_pkg::pp_width + 1];
    mul_pkg::pp_t                 col_sum;
    mul_pkg::pp_t                 col_cout;   // bit j has weight j+1

    assign col_carry[0] = '0;  // nothing below bit 0

    for (genvar j = 0; j < mul_pkg::pp_width; j++) begin : g_col
        // gather bit j of every partial product
        for (genvar k = 0; k < mul_pkg::pp_count; k++) begin : g_bit
            assign col_bits[j][k] = pp[k][j];
        end

        csa_column csa_column_i (
            .bits       (col_bits[j]),
            .cin        (col_carry[j]),
            .cout_group (col_carry[j+1]),
            .cout       (col_cout[j]),
            .sum        (col_sum[j])
        );
    end

    // col_carry[pp_width] falls off the top, product is taken mod 2^68

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q   <= '0;
            carry_q <= '0;
        end else begin
            sum_q   <= col_sum;
            carry_q <= col_cout;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mul_final_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_final_add (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire logic             capture,
    input  wire mul_pkg::pp_t     sum_q,
    input  wire mul_pkg::pp_t     carry_q,
    input  wire mul_pkg::mul_op_t op_q,
    output mul_pkg::word_t        result
);

    mul_pkg::pp_t   full;  // only the low 64 bits are meaningful
    mul_pkg::word_t sel_word;

    // carry vector sits one weight above the sum vector
    assign full = sum_q + (carry_q << 1);

    always_comb begin
        if (op_q == mul_pkg::op_mul) begin
            sel_word = full[mul_pkg::xlen-1:0];
        end else begin
            sel_word = full[2*mul_pkg::xlen-1:mul_pkg::xlen];  // high word
        end
    end

    // held between captures
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (capture) begin
            result <= sel_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mul_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_timer #(
    parameter int timer_width = 2,
    parameter int latency     = 3
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire logic load,
    output logic      expired
);

    logic [timer_width-1:0] count;
    logic                   active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count  <= '0;
            active <= 1'b0;
        end else if (load) begin
            count  <= timer_width'(latency - 2);  // expired lands latency-1 after load
            active <= 1'b1;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign expired = active && (count == '0);

    // controller only loads from idle, so a running count is never cut short
    a_no_reload: assert property (@(posedge clk) disable iff (!rst_n) load |-> !active);

endmodule

`default_nettype wire

// ==== hw/mul_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_ctrl (
    input  wire       clk,
    input  wire       rst_n,
    input  wire logic start,
    input  wire logic expired,
    output logic      accept,
    output logic      capture,
    output logic      busy,
    output logic      done
);

    mul_pkg::ctrl_state_t state;
    mul_pkg::ctrl_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            mul_pkg::st_idle: if (start) state_nxt = mul_pkg::st_run;
            mul_pkg::st_run:  if (expired) state_nxt = mul_pkg::st_done;
            mul_pkg::st_done: state_nxt = mul_pkg::st_idle;
            default:          state_nxt = mul_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mul_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign accept  = start && (state == mul_pkg::st_idle);  // start while busy is dropped
    assign capture = expired && (state == mul_pkg::st_run);
    assign busy    = (state != mul_pkg::st_idle);
    assign done    = (state == mul_pkg::st_done);   // same cycle the result appears

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

    a_done_after_run: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> $past(state) == mul_pkg::st_run
    );

endmodule

`default_nettype wire

// ==== hw/mul_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit_top #(
    parameter int timer_width = 2,
    parameter int latency     = 3   // register stages from start to done
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire logic             start,
    input  wire mul_pkg::word_t   op_a,
    input  wire mul_pkg::word_t   op_b,
    input  wire mul_pkg::mul_op_t op,
    output logic                  busy,
    output logic                  done,
    output mul_pkg::word_t        result
);

    logic             accept;
    logic             capture;
    logic             expired;
    mul_pkg::mul_op_t op_q;
    mul_pkg::pp_t     pp [mul_pkg::pp_count];
    mul_pkg::pp_t     sum_q;
    mul_pkg::pp_t     carry_q;

    mul_ctrl mul_ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .expired (expired),
        .accept  (accept),
        .capture (capture),
        .busy    (busy),
        .done    (done)
    );

    mul_timer #(
        .timer_width (timer_width),
        .latency     (latency)
    ) mul_timer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (accept),
        .expired (expired)
    );

    booth_pp_gen booth_pp_gen_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (accept),
        .op_a  (op_a),
        .op_b  (op_b),
        .op    (op),
        .op_q  (op_q),
        .pp    (pp)
    );

    wallace_tree wallace_tree_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pp      (pp),
        .sum_q   (sum_q),
        .carry_q (carry_q)
    );

    mul_final_add mul_final_add_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .sum_q   (sum_q),
        .carry_q (carry_q),
        .op_q    (op_q),
        .result  (result)
    );

endmodule

`default_nettype wire

// ==== sim/tb_mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mul_unit;

    localparam int timer_width = 2;
    localparam int latency     = 3;

    // corners 5x5x4, random 200, timing 4, busy start 1, hold 1
    localparam int num_ops        = 5 * 5 * 4 + 200 + 4 + 1 + 1;
    localparam int watchdog_limit = num_ops * (latency + 2) + 4 + 100;

    logic             clk;
    logic             rst_n;
    logic             start;
    mul_pkg::word_t   op_a;
    mul_pkg::word_t   op_b;
    mul_pkg::mul_op_t op;
    logic             busy;
    logic             done;
    mul_pkg::word_t   result;

    logic [31:0] exp_q [$];   // expected results in issue order
    string       name_q [$];
    logic [31:0] lfsr_state = 32'h95af_b389;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int done_count  = 0;
    int mark_errors = 0;
    int mark_checks = 0;

    mul_unit_top #(
        .timer_width (timer_width),
        .latency     (latency)
    ) mul_unit_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op_a   (op_a),
        .op_b   (op_b),
        .op     (op),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected word, each operand widened to 64 bits as the op says
    function automatic logic [31:0] ref_mul(input logic [31:0] a, input logic [31:0] b,
                                            input mul_pkg::mul_op_t o);
        logic        a_signed;
        logic        b_signed;
        logic [63:0] a_wide;
        logic [63:0] b_wide;
        logic [63:0] prod;
        a_signed = (o == mul_pkg::op_mulh) || (o == mul_pkg::op_mulhsu);
        b_signed = (o == mul_pkg::op_mulh);
        a_wide   = a_signed ? {{32{a[31]}}, a} : {32'h0, a};
        b_wide   = b_signed ? {{32{b[31]}}, b} : {32'h0, b};
        prod     = a_wide * b_wide;  // low 64 bits are exact for two's complement
        if (o == mul_pkg::op_mul) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic begin_test();
        mark_errors = error_count;
        mark_checks = check_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%-10s %0d checks, %0d errors", name, check_count - mark_checks,
                 error_count - mark_errors);
    endtask

    // one start strobe, then watch busy and done until the unit is idle again
    task automatic issue_op(input string name, input logic [31:0] a, input logic [31:0] b,
                            input mul_pkg::mul_op_t o);
        int          cycles;
        logic [31:0] prev;
        @(negedge clk);
        prev  = result;  // last result, must stay until the new done
        start = 1'b1;
        op_a  = a;
        op_b  = b;
        op    = o;
        exp_q.push_back(ref_mul(a, b, o));
        name_q.push_back(name);
        cycles = 0;
        do begin
            @(negedge clk);
            start = 1'b0;
            cycles++;
            check({name, " busy"}, 32'h1, 32'(busy));
            if (!done) begin
                check({name, " held"}, prev, result);
            end
        end while (!done && cycles < 2 * latency + 2);
        check({name, " latency"}, 32'(latency), 32'(cycles));
        @(negedge clk);
        check({name, " done width"}, 32'h0, 32'(done));
        check({name, " busy after done"}, 32'h0, 32'(busy));
    endtask

    // compare each result as done comes
    initial begin : compare
        logic [31:0] expected;
        string       nm;
        forever begin
            @(negedge clk);
            if (rst_n && done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    $display("done pulsed with no operation outstanding");
                    error_count++;
                end else begin
                    expected = exp_q.pop_front();
                    nm       = name_q.pop_front();
                    check(nm, expected, result);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_limit) @(posedge clk);
        $display("done never came, run stopped after %0d cycles", watchdog_limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]    corners [5];
        logic [31:0]    ra;
        logic [31:0]    rb;
        logic [31:0]    ro;
        logic [31:0]    held;
        int             cycles;
        int             dones_before;
        corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                    32'h8000_0000, 32'h7fff_ffff};
        rst_n = 1'b0;
        start = 1'b0;
        op_a  = '0;
        op_b  = '0;
        op    = mul_pkg::op_mul;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        @(negedge clk);
        check("reset result", 32'h0, result);
        check("reset done", 32'h0, 32'(done));
        check("reset busy", 32'h0, 32'(busy));
        end_test("reset");

        begin_test();
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int k = 0; k < 4; k++) begin
                    issue_op("corners", corners[i], corners[j], mul_pkg::mul_op_t'(k));
                end
            end
        end
        end_test("corners");

        begin_test();
        for (int n = 0; n < 200; n++) begin
            draw_bits(32, ra);
            draw_bits(32, rb);
            draw_bits(2, ro);
            issue_op("random", ra, rb, mul_pkg::mul_op_t'(ro[1:0]));
        end
        end_test("random");

        // latency, busy window and done width are checked inside issue_op
        begin_test();
        issue_op("timing", 32'h0000_1234, 32'h0000_5678, mul_pkg::op_mul);
        issue_op("timing", 32'hdead_beef, 32'h1234_5678, mul_pkg::op_mulh);
        issue_op("timing", 32'h8000_0001, 32'hffff_fffe, mul_pkg::op_mulhsu);
        issue_op("timing", 32'hcafe_f00d, 32'hcafe_f00d, mul_pkg::op_mulhu);
        end_test("timing");

        begin_test();
        dones_before = done_count;
        @(negedge clk);
        start = 1'b1;
        op_a  = 32'h1357_9bdf;
        op_b  = 32'h2468_ace0;
        op    = mul_pkg::op_mulhu;
        exp_q.push_back(ref_mul(32'h1357_9bdf, 32'h2468_ace0, mul_pkg::op_mulhu));
        name_q.push_back("busy start");
        @(negedge clk);
        check("busy start busy", 32'h1, 32'(busy));
        start = 1'b1;  // second start, must be dropped
        op_a  = 32'hffff_0000;
        op_b  = 32'h0000_ffff;
        op    = mul_pkg::op_mul;
        cycles = 1;
        while (!done && cycles < 2 * latency + 2) begin
            @(negedge clk);
            start = 1'b0;
            cycles++;
        end
        check("busy start latency", 32'(latency), 32'(cycles));
        repeat (latency + 3) @(negedge clk);
        check("busy start done count", 32'h1, 32'(done_count - dones_before));
        end_test("busy");

        begin_test();
        issue_op("hold", 32'h0bad_cafe, 32'h0000_0010, mul_pkg::op_mul);
        held = result;
        check("hold value", ref_mul(32'h0bad_cafe, 32'h0000_0010, mul_pkg::op_mul), held);
        repeat (6) begin
            @(negedge clk);
            check("hold", held, result);
        end
        end_test("hold");

        if (exp_q.size() != 0) begin
            $display("%0d operations never returned a result", exp_q.size());
            error_count++;
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/mul_pkg.sv
hw/csa_column.sv
hw/booth_pp_gen.sv
hw/wallace_tree.sv
hw/mul_final_add.sv
hw/mul_timer.sv
hw/mul_ctrl.sv
hw/mul_unit_top.sv
sim/tb_mul_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mul_unit
FILELIST  = files.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
